// ==== Core.sv ====
`timescale 1ns/1ps
`default_nettype none

module Core import miniCorePkg::*; (
    input wire clk,
    input wire rst,
    input wire en,
    input wire [31:0] instrRaw,
    output logic [29:0] instrAddr,
    output logic instrReadEnable,
    input wire [31:0] memReadData,
    output logic [29:0] memAddr,
    output logic [31:0] memWriteData,
    output logic memWriteEnable,
    output logic memReadEnable,
    output logic [3:0] memWriteMask,
    output logic halt
);

logic stall;
logic lsBusy;
logic [31:0] fetchWord;
logic [31:0] fetchPc;
logic fetchValid;
logic [31:0] rsData0;
logic [31:0] rsData1;
BranchProv branch;
DecUOp decUop;
DecUOp execUop;
ResUOp aluRes;
ResUOp lsRes;
ResUOp wbRes;
MemReq memReq;

// Word seen during load completion was already executed
assign stall = memReq.readEnable || (!en && !lsBusy) || halt;

ProgramCounter pc0 (
    .clk(clk),
    .rst(rst),
    .stall(stall),
    .IN_branch(branch),
    .instrRaw(instrRaw),
    .instrAddr(instrAddr),
    .instrReadEnable(instrReadEnable),
    .fetchWord(fetchWord),
    .fetchPc(fetchPc),
    .fetchValid(fetchValid)
);

InstrDecoder dec0 (
    .fetchWord(fetchWord),
    .fetchPc(fetchPc),
    .fetchValid(fetchValid),
    .uop(decUop)
);

always_comb begin
    execUop = decUop;
    execUop.valid = decUop.valid && en && !halt && !lsBusy;
end

RegFile rf0 (
    .clk(clk),
    .rst(rst),
    .readAddr0(decUop.rs1),
    .readAddr1(decUop.rs2),
    .readData0(rsData0),
    .readData1(rsData1),
    .IN_wb(wbRes)
);

IntALU alu0 (
    .uop(execUop),
    .opA(rsData0),
    .opB(rsData1),
    .OUT_res(aluRes),
    .OUT_branch(branch)
);

LoadStore lsu0 (
    .clk(clk),
    .rst(rst),
    .uop(execUop),
    .base(rsData0),
    .storeData(rsData1),
    .memReadData(memReadData),
    .OUT_mem(memReq),
    .OUT_res(lsRes),
    .busy(lsBusy)
);

assign wbRes = lsRes.valid ? lsRes : aluRes;    // Load is the older instruction

assign memAddr = memReq.addr;
assign memWriteData = memReq.writeData;
assign memWriteEnable = memReq.writeEnable;
assign memReadEnable = memReq.readEnable;
assign memWriteMask = memReq.writeMask;

always_ff @(posedge clk) begin
    if (rst)
        halt <= 1'b0;
    else if (execUop.valid && execUop.fu == FU_HALT)
        halt <= 1'b1;
end

endmodule

`default_nettype wire

// ==== Core_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "miniCore_consts.svh"

module Core_tb;

typedef struct packed {
    logic [29:0] addr;
    logic [31:0] data;          // Only the masked lanes are meaningful
    logic [3:0] mask;
} StoreRec;

localparam logic [31:0] ebreakWord = 32'h00100073;

logic clk;
logic rst;
logic en;
logic [31:0] instrRaw;
logic [29:0] instrAddr;
logic instrReadEnable;
logic [31:0] memReadData;
logic [29:0] memAddr;
logic [31:0] memWriteData;
logic memWriteEnable;
logic memReadEnable;
logic [3:0] memWriteMask;
logic halt;

logic [31:0] prog [0:255];
int progLen;
logic [31:0] dmem [0:63];
logic [31:0] refMem [0:63];
StoreRec expStores [$];
string testName;
integer seed = 32'h389a5354;
logic enToggle;
logic [31:0] instrNext;
logic [31:0] readNext;

Core dut0 (
    .clk(clk),
    .rst(rst),
    .en(en),
    .instrRaw(instrRaw),
    .instrAddr(instrAddr),
    .instrReadEnable(instrReadEnable),
    .memReadData(memReadData),
    .memAddr(memAddr),
    .memWriteData(memWriteData),
    .memWriteEnable(memWriteEnable),
    .memReadEnable(memReadEnable),
    .memWriteMask(memWriteMask),
    .halt(halt)
);

always #4 clk = ~clk;

////////////////////
// Memory models
always @(posedge clk) begin
    if (instrReadEnable === 1'b1)
        instrNext <= prog[instrAddr[7:0]];
    if (!rst && memReadEnable === 1'b1)
        readNext <= dmem[memAddr[5:0]];
    if (!rst && memWriteEnable === 1'b1) begin
        for (int b = 0; b < 4; b++)
            if (memWriteMask[b])
                dmem[memAddr[5:0]][8*b +: 8] = memWriteData[8*b +: 8];
    end
end

always @(negedge clk) begin
    instrRaw <= instrNext;      // Answer lands one cycle after the request
    memReadData <= readNext;
    en <= enToggle ? (({$random(seed)} % 3) != 0) : 1'b1;
end

////////////////////
// Store stream check
always @(posedge clk) begin
    StoreRec exp;
    logic [31:0] laneMask;
    if (!rst && memWriteEnable === 1'b1) begin
        if (expStores.size() == 0) begin
            $display("ERROR: store to word %h in test %s that the model never made",
                     memAddr, testName);
            $display("Simulation FAILED");
            $fatal(1);
        end else begin
            exp = expStores.pop_front();
            laneMask = {{8{memWriteMask[3]}}, {8{memWriteMask[2]}},
                        {8{memWriteMask[1]}}, {8{memWriteMask[0]}}};
            checkValue(testName, {exp.addr, exp.data, exp.mask},
                       {memAddr, memWriteData & laneMask, memWriteMask});
        end
    end
end

task automatic checkValue(input string name, input logic [71:0] expected,
                          input logic [71:0] actual);
    if (expected !== actual) begin
        $display("MISMATCH test=%s expected=%h actual=%h", name, expected, actual);
        $display("Simulation FAILED");
        $fatal(1);
    end
endtask

////////////////////
// Instruction encoders
function automatic logic [31:0] aluReg(input logic [6:0] f7, input logic [2:0] f3,
                                       input logic [4:0] rd, rs1, rs2);
    return {f7, rs2, rs1, f3, rd, `OPC_OP};
endfunction

function automatic logic [31:0] aluImm(input logic [2:0] f3, input logic [4:0] rd, rs1,
                                       input logic [11:0] imm);
    return {imm, rs1, f3, rd, `OPC_OP_IMM};
endfunction

function automatic logic [31:0] lw(input logic [4:0] rd, rs1, input logic [11:0] off);
    return {off, rs1, 3'b010, rd, `OPC_LOAD};
endfunction

function automatic logic [31:0] store(input logic [2:0] f3, input logic [4:0] rs2, rs1,
                                      input logic [11:0] off);
    return {off[11:5], rs2, rs1, f3, off[4:0], `OPC_STORE};
endfunction

function automatic logic [31:0] branch(input logic [2:0] f3, input logic [4:0] rs1, rs2,
                                       input logic [12:0] off);
    return {off[12], off[10:5], rs2, rs1, f3, off[4:1], off[11], `OPC_BRANCH};
endfunction

function automatic logic [31:0] jal(input logic [4:0] rd, input logic [20:0] off);
    return {off[20], off[10:1], off[11], off[19:12], rd, `OPC_JAL};
endfunction

function automatic logic [31:0] lui(input logic [4:0] rd, input logic [19:0] upper);
    return {upper, rd, `OPC_LUI};
endfunction

function automatic logic [31:0] fillWord(input int idx);
    return (idx * 32'h9E3779B1) ^ 32'h5A5A0000 ^ idx;
endfunction

task automatic emit(input logic [31:0] word);
    prog[progLen] = word;
    progLen++;
endtask

task automatic startProgram(input string name);
    testName = name;
    progLen = 0;
    for (int i = 0; i < 256; i++)
        prog[i] = 32'd0;        // Unsupported encoding, acts as a no-op
endtask

////////////////////
// Instruction-set model
function automatic void refRun();
    logic [31:0] r [0:31];
    logic [31:0] pc;
    logic [31:0] next;
    logic [31:0] w;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] addr;
    logic [31:0] wr;
    logic wen;
    logic done;
    int steps;
    StoreRec st;
    expStores.delete();
    for (int i = 0; i < 32; i++)
        r[i] = 32'd0;
    pc = `RESET_PC;
    done = 1'b0;
    steps = 0;
    while (!done && steps < 5000) begin
        w = prog[pc[9:2]];
        a = r[w[19:15]];
        b = r[w[24:20]];
        next = pc + 32'd4;
        wen = 1'b0;
        wr = 32'd0;
        steps++;
        case (w[6:0])
            `OPC_OP: begin
                wen = 1'b1;
                case (w[14:12])
                    3'b000: wr = w[30] ? a - b : a + b;
                    3'b111: wr = a & b;
                    3'b110: wr = a | b;
                    3'b100: wr = a ^ b;
                    3'b010: wr = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    default: wen = 1'b0;
                endcase
            end
            `OPC_OP_IMM: begin
                wen = 1'b1;
                b = {{20{w[31]}}, w[31:20]};
                case (w[14:12])
                    3'b000: wr = a + b;
                    3'b111: wr = a & b;
                    3'b110: wr = a | b;
                    3'b100: wr = a ^ b;
                    default: wen = 1'b0;
                endcase
            end
            `OPC_LUI: begin
                wen = 1'b1;
                wr = {w[31:12], 12'd0};
            end
            `OPC_LOAD: begin
                addr = a + {{20{w[31]}}, w[31:20]};
                wen = 1'b1;
                wr = refMem[addr[7:2]];
            end
            `OPC_STORE: begin
                addr = a + {{20{w[31]}}, w[31:25], w[11:7]};
                st.addr = addr[31:2];
                if (w[14:12] == 3'b000) begin
                    st.mask = 4'b0001 << addr[1:0];
                    st.data = {24'd0, b[7:0]} << (8 * addr[1:0]);
                    refMem[addr[7:2]][8*addr[1:0] +: 8] = b[7:0];
                end else begin
                    st.mask = 4'b1111;
                    st.data = b;
                    refMem[addr[7:2]] = b;
                end
                expStores.push_back(st);
            end
            `OPC_BRANCH: begin
                if ((w[14:12] == 3'b000) ? (a == b) : (a != b))
                    next = pc + {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
            end
            `OPC_JAL: begin
                wen = 1'b1;
                wr = pc + 32'd4;
                next = pc + {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
            end
            `OPC_SYSTEM: done = 1'b1;
            default: wen = 1'b0;
        endcase
        if (wen && w[11:7] != 5'd0)
            r[w[11:7]] = wr;
        pc = next;
    end
endfunction

task automatic runProgram();
    int cycles;
    for (int i = 0; i < 64; i++) begin
        dmem[i] = fillWord(i);
        refMem[i] = fillWord(i);
    end
    refRun();
    @(negedge clk);
    rst = 1'b1;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    cycles = 0;
    while (halt !== 1'b1) begin
        @(negedge clk);
        cycles++;
        if (cycles > 3000) begin
            $display("ERROR: core never halted in test %s", testName);
            $display("Simulation FAILED");
            $fatal(1);
        end
    end
    // Halt holds and both ports stay idle, late stores are caught too
    for (int i = 0; i < 6; i++) begin
        @(negedge clk);
        checkValue({testName, " quietAfterHalt"}, {1'b1, 3'b000},
                   {halt, instrReadEnable, memReadEnable, memWriteEnable});
    end
    checkValue({testName, " storeCount"}, 72'd0, expStores.size());
    for (int i = 0; i < 64; i++)
        checkValue({testName, " finalMemory"}, refMem[i], dmem[i]);
endtask

initial begin
    int n;
    logic [31:0] rnd;
    clk = 1'b0;
    rst = 1'b1;
    en = 1'b1;
    enToggle = 1'b0;
    instrRaw = 32'd0;
    memReadData = 32'd0;
    instrNext = 32'd0;
    readNext = 32'd0;

    startProgram("arith");
    emit(aluImm(3'b000, 1, 0, 123));
    emit(aluImm(3'b000, 2, 0, -45));
    emit(aluReg(7'h00, 3'b000, 3, 1, 2));
    emit(aluReg(7'h20, 3'b000, 4, 1, 2));
    emit(aluReg(7'h00, 3'b111, 5, 1, 2));
    emit(aluReg(7'h00, 3'b110, 6, 1, 2));
    emit(aluReg(7'h00, 3'b100, 7, 1, 2));
    emit(aluReg(7'h00, 3'b010, 8, 2, 1));
    emit(aluReg(7'h00, 3'b010, 9, 1, 2));
    emit(aluImm(3'b111, 10, 1, 12'h0F0));
    emit(aluImm(3'b110, 11, 2, 12'h700));
    emit(aluImm(3'b100, 12, 1, -1));
    emit(lui(13, 20'hABCDE));
    emit(aluImm(3'b000, 0, 1, 5));             // x0 must stay zero
    emit(aluReg(7'h00, 3'b000, 0, 1, 1));
    emit(aluImm(3'b000, 14, 0, 64));
    for (int r = 0; r < 14; r++)
        emit(store(3'b010, r, 14, 4 * r));
    emit(ebreakWord);
    runProgram();

    startProgram("branch");
    emit(aluImm(3'b000, 1, 0, 0));
    emit(aluImm(3'b000, 2, 0, 5));
    emit(aluImm(3'b000, 3, 0, 12'h080));
    emit(aluImm(3'b000, 1, 1, 1));             // Loop head
    emit(store(3'b010, 1, 3, 0));
    emit(aluImm(3'b000, 3, 3, 4));
    emit(branch(3'b001, 1, 2, -12));
    emit(branch(3'b000, 1, 2, 8));
    emit(aluImm(3'b000, 4, 0, 99));            // Skipped
    emit(store(3'b010, 4, 3, 0));
    emit(jal(5, 12));
    emit(aluImm(3'b000, 6, 0, 77));
    emit(store(3'b010, 6, 3, 4));
    emit(store(3'b010, 5, 3, 8));
    emit(branch(3'b000, 1, 0, 8));             // Not taken
    emit(store(3'b010, 2, 3, 12));
    emit(ebreakWord);
    runProgram();

    startProgram("loadUse");
    emit(aluImm(3'b000, 1, 0, 12'h020));
    emit(lui(2, 20'h12345));
    emit(aluImm(3'b000, 2, 2, 12'h678));
    emit(aluImm(3'b000, 3, 0, -300));
    emit(store(3'b010, 2, 1, 0));
    emit(store(3'b010, 3, 1, 4));
    emit(lw(4, 1, 0));
    emit(aluReg(7'h00, 3'b000, 5, 4, 4));      // Uses the load result at once
    emit(lw(6, 1, 4));
    emit(aluReg(7'h00, 3'b000, 7, 6, 4));
    emit(store(3'b010, 5, 1, 8));
    emit(store(3'b010, 7, 1, 12));
    emit(lw(8, 1, 8));
    emit(store(3'b010, 8, 1, 16));
    emit(lw(9, 1, 20));                        // Word from the fill pattern
    emit(store(3'b010, 9, 1, 24));
    emit(ebreakWord);
    runProgram();

    startProgram("byteStore");
    emit(aluImm(3'b000, 1, 0, 12'h060));
    emit(aluImm(3'b000, 2, 0, 12'h011));
    emit(store(3'b000, 2, 1, 0));
    emit(aluImm(3'b000, 2, 0, 12'h022));
    emit(store(3'b000, 2, 1, 1));
    emit(aluImm(3'b000, 2, 0, 12'h1A3));
    emit(store(3'b000, 2, 1, 2));
    emit(aluImm(3'b000, 2, 0, -2));
    emit(store(3'b000, 2, 1, 3));
    emit(lw(3, 1, 0));
    emit(store(3'b010, 3, 1, 4));
    emit(store(3'b000, 2, 1, 9));              // One lane of a pattern word
    emit(lw(4, 1, 8));
    emit(store(3'b010, 4, 1, 12));
    emit(ebreakWord);
    runProgram();

    startProgram("haltAndEn");
    n = 8 + ({$random(seed)} % 24);
    for (int k = 0; k < n; k++) begin
        rnd = $random(seed);
        if (rnd[1:0] != 2'd0)
            emit(aluImm(3'b000, {2'b0, rnd[4:2]}, {2'b0, rnd[7:5]}, rnd[19:8]));
        else
            emit(store(3'b010, {2'b0, rnd[4:2]}, 0, 12'h080 + {rnd[11:8], 2'b0}));
    end
    emit(ebreakWord);
    emit(store(3'b010, 1, 0, 12'h0C0));        // Never reached
    emit(store(3'b010, 2, 0, 12'h0C4));
    enToggle = 1'b1;
    runProgram();
    enToggle = 1'b0;

    $display("Simulation PASSED");
    $finish;
end

endmodule

`default_nettype wire

// ==== InstrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "miniCore_consts.svh"

module InstrDecoder import miniCorePkg::*; (
    input wire [31:0] fetchWord,
    input wire [31:0] fetchPc,
    input wire fetchValid,
    output DecUOp uop
);

logic [6:0] opcode;
logic [2:0] funct3;
logic [6:0] funct7;
logic [31:0] immI;
logic [31:0] immS;
logic [31:0] immB;
logic [31:0] immU;
logic [31:0] immJ;
logic supported;

assign opcode = fetchWord[6:0];
assign funct3 = fetchWord[14:12];
assign funct7 = fetchWord[31:25];

////////////////////
// Immediate formats
assign immI = {{20{fetchWord[31]}}, fetchWord[31:20]};
assign immS = {{20{fetchWord[31]}}, fetchWord[31:25], fetchWord[11:7]};
assign immB = {{19{fetchWord[31]}}, fetchWord[31], fetchWord[7],
               fetchWord[30:25], fetchWord[11:8], 1'b0};
assign immU = {fetchWord[31:12], 12'b0};
assign immJ = {{11{fetchWord[31]}}, fetchWord[31], fetchWord[19:12],
               fetchWord[20], fetchWord[30:21], 1'b0};

always_comb begin
    uop = '0;
    supported = 1'b1;
    uop.pc = fetchPc;
    uop.rs1 = fetchWord[19:15];
    uop.rs2 = fetchWord[24:20];
    uop.fu = FU_ALU;
    uop.aluOp = ALU_ADD;
    case (opcode)
        `OPC_OP: begin
            uop.rd = fetchWord[11:7];
            case ({funct7, funct3})
                {7'h00, 3'b000}: uop.aluOp = ALU_ADD;
                {7'h20, 3'b000}: uop.aluOp = ALU_SUB;
                {7'h00, 3'b111}: uop.aluOp = ALU_AND;
                {7'h00, 3'b110}: uop.aluOp = ALU_OR;
                {7'h00, 3'b100}: uop.aluOp = ALU_XOR;
                {7'h00, 3'b010}: uop.aluOp = ALU_SLT;
                default: supported = 1'b0;
            endcase
        end
        `OPC_OP_IMM: begin
            uop.rd = fetchWord[11:7];
            uop.imm = immI;
            uop.useImm = 1'b1;
            case (funct3)
                3'b000: uop.aluOp = ALU_ADD;
                3'b111: uop.aluOp = ALU_AND;
                3'b110: uop.aluOp = ALU_OR;
                3'b100: uop.aluOp = ALU_XOR;
                default: supported = 1'b0;
            endcase
        end
        `OPC_LUI: begin
            uop.rd = fetchWord[11:7];
            uop.imm = immU;
            uop.useImm = 1'b1;
            uop.aluOp = ALU_LUI;
        end
        `OPC_LOAD: begin
            uop.fu = FU_LSU;
            uop.rd = fetchWord[11:7];
            uop.imm = immI;
            uop.isLoad = 1'b1;
            supported = (funct3 == 3'b010);     // LW only
        end
        `OPC_STORE: begin
            uop.fu = FU_LSU;
            uop.imm = immS;
            uop.isByte = (funct3 == 3'b000);
            supported = (funct3 == 3'b010) || (funct3 == 3'b000);
        end
        `OPC_BRANCH: begin
            uop.imm = immB;
            case (funct3)
                3'b000: uop.aluOp = ALU_BEQ;
                3'b001: uop.aluOp = ALU_BNE;
                default: supported = 1'b0;
            endcase
        end
        `OPC_JAL: begin
            uop.rd = fetchWord[11:7];
            uop.imm = immJ;
            uop.aluOp = ALU_JAL;
        end
        `OPC_SYSTEM: begin
            uop.fu = FU_HALT;
            supported = (fetchWord[31:7] == 25'h0002000);   // EBREAK
        end
        default: supported = 1'b0;
    endcase
    uop.valid = fetchValid && supported;
end

endmodule

`default_nettype wire

// ==== IntALU.sv ====
`timescale 1ns/1ps
`default_nettype none

module IntALU import miniCorePkg::*; (
    input DecUOp uop,
    input wire [31:0] opA,
    input wire [31:0] opB,
    output ResUOp OUT_res,
    output BranchProv OUT_branch
);

logic active;
logic [31:0] opBEff;
logic [31:0] result;
logic taken;

assign active = uop.valid && (uop.fu == FU_ALU);
assign opBEff = uop.useImm ? uop.imm : opB;

always_comb begin
    result = 32'd0;
    taken = 1'b0;
    case (uop.aluOp)
        ALU_ADD: result = opA + opBEff;
        ALU_SUB: result = opA - opBEff;
        ALU_AND: result = opA & opBEff;
        ALU_OR:  result = opA | opBEff;
        ALU_XOR: result = opA ^ opBEff;
        ALU_SLT: result = {31'd0, $signed(opA) < $signed(opBEff)};
        ALU_LUI: result = uop.imm;
        ALU_BEQ: taken = (opA == opB);
        ALU_BNE: taken = (opA != opB);
        ALU_JAL: begin
            result = uop.pc + 32'd4;    // Link address
            taken = 1'b1;
        end
        default: result = 32'd0;
    endcase
end

assign OUT_res.valid = active;
assign OUT_res.rd = uop.rd;
assign OUT_res.result = result;

assign OUT_branch.taken = active && taken;
assign OUT_branch.dstPC = uop.pc + uop.imm;     // Same target form for B and J

endmodule

`default_nettype wire

// ==== LoadStore.sv ====
`timescale 1ns/1ps
`default_nettype none

module LoadStore import miniCorePkg::*; (
    input wire clk,
    input wire rst,
    input DecUOp uop,
    input wire [31:0] base,
    input wire [31:0] storeData,
    input wire [31:0] memReadData,
    output MemReq OUT_mem,
    output ResUOp OUT_res,
    output logic busy
);

logic active;
logic [31:0] addr;
logic [4:0] loadRd;

assign active = uop.valid && (uop.fu == FU_LSU);
assign addr = base + uop.imm;

////////////////////
// Request side
assign OUT_mem.addr = addr[31:2];
assign OUT_mem.readEnable = active && uop.isLoad;
assign OUT_mem.writeEnable = active && !uop.isLoad;
assign OUT_mem.writeData = uop.isByte ? {4{storeData[7:0]}} : storeData;
assign OUT_mem.writeMask = uop.isByte ? (4'b0001 << addr[1:0]) : 4'b1111;

////////////////////
// Load completion
always_ff @(posedge clk) begin
    if (rst)
        busy <= 1'b0;
    else
        busy <= OUT_mem.readEnable;
end

always_ff @(posedge clk) begin
    if (OUT_mem.readEnable)
        loadRd <= uop.rd;
end

assign OUT_res.valid = busy;
assign OUT_res.rd = loadRd;
assign OUT_res.result = memReadData;

a_readWriteExclusive: assert property (@(posedge clk) disable iff (rst)
    !(OUT_mem.readEnable && OUT_mem.writeEnable))
    else $error("LoadStore: read and write in the same cycle");

// Core must not issue another access while a load completes
a_noIssueWhileBusy: assert property (@(posedge clk) disable iff (rst)
    busy |-> !(OUT_mem.readEnable || OUT_mem.writeEnable))
    else $error("LoadStore: access issued during load completion");

endmodule

`default_nettype wire

// ==== ProgramCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "miniCore_consts.svh"

module ProgramCounter import miniCorePkg::*; (
    input wire clk,
    input wire rst,
    input wire stall,
    input BranchProv IN_branch,
    input wire [31:0] instrRaw,
    output logic [29:0] instrAddr,
    output logic instrReadEnable,
    output logic [31:0] fetchWord,
    output logic [31:0] fetchPc,
    output logic fetchValid
);

logic [31:0] pc;            // Address requested this cycle
logic [31:0] inFlightPc;
logic inFlightValid;
logic [31:0] instrBackup;
logic useBackup;

assign instrAddr = pc[31:2];
assign instrReadEnable = !stall;
assign fetchWord = useBackup ? instrBackup : instrRaw;
assign fetchPc = inFlightPc;
assign fetchValid = inFlightValid;

always_ff @(posedge clk) begin
    if (rst) begin
        pc <= `RESET_PC;
        inFlightValid <= 1'b0;
        useBackup <= 1'b0;
    end else if (IN_branch.taken) begin
        pc <= IN_branch.dstPC;
        inFlightValid <= 1'b0;  // Word already requested is dropped
        useBackup <= 1'b0;
    end else if (stall) begin
        useBackup <= 1'b1;      // Memory output not valid next cycle
    end else begin
        pc <= pc + 32'd4;
        inFlightValid <= 1'b1;
        useBackup <= 1'b0;
    end
end

always_ff @(posedge clk) begin
    if (stall)
        instrBackup <= fetchWord;
    if (!stall)
        inFlightPc <= pc;
end

a_flushAfterBranch: assert property (@(posedge clk) disable iff (rst)
    IN_branch.taken |=> !fetchValid)
    else $error("ProgramCounter: word after taken branch not flushed");

endmodule

`default_nettype wire

// ==== RegFile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "miniCore_consts.svh"

module RegFile import miniCorePkg::*; (
    input wire clk,
    input wire rst,
    input wire [4:0] readAddr0,
    input wire [4:0] readAddr1,
    output logic [31:0] readData0,
    output logic [31:0] readData1,
    input ResUOp IN_wb
);

logic [31:0] regs [0:`NUM_REGS-1];
logic wbWrites;

assign wbWrites = IN_wb.valid && (IN_wb.rd != 5'd0);   // x0 stays zero

assign readData0 = regs[readAddr0];
assign readData1 = regs[readAddr1];

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < `NUM_REGS; i++)
            regs[i] <= 32'd0;
    end else if (wbWrites) begin
        regs[IN_wb.rd] <= IN_wb.result;
    end
end

endmodule

`default_nettype wire

// ==== miniCore.f ====
+incdir+.
miniCorePkg.sv
ProgramCounter.sv
InstrDecoder.sv
RegFile.sv
IntALU.sv
LoadStore.sv
Core.sv
Core_tb.sv

// ==== miniCorePkg.sv ====
`default_nettype none

package miniCorePkg;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT,
        ALU_LUI,
        ALU_BEQ,
        ALU_BNE,
        ALU_JAL
    } AluOp;

    typedef enum logic [1:0] {
        FU_ALU,
        FU_LSU,
        FU_HALT
    } FuncUnit;

    typedef struct packed {
        logic valid;
        logic [31:0] pc;
        FuncUnit fu;
        AluOp aluOp;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;     // Zero when nothing is written back
        logic [31:0] imm;
        logic useImm;
        logic isLoad;
        logic isByte;       // SB, otherwise a full word
    } DecUOp;

    typedef struct packed {
        logic taken;
        logic [31:0] dstPC;
    } BranchProv;

    typedef struct packed {
        logic valid;
        logic [4:0] rd;
        logic [31:0] result;
    } ResUOp;

    typedef struct packed {
        logic [29:0] addr;  // Word address
        logic [31:0] writeData;
        logic writeEnable;
        logic readEnable;
        logic [3:0] writeMask;
    } MemReq;

endpackage

`default_nettype wire

// ==== miniCore_consts.svh ====
`ifndef MINICORE_CONSTS_SVH
`define MINICORE_CONSTS_SVH

// Fetch start address after reset
`define RESET_PC 32'h0000_0000

`define NUM_REGS 32

////////////////////
// RV32I opcode field values
`define OPC_OP      7'b0110011
`define OPC_OP_IMM  7'b0010011
`define OPC_LUI     7'b0110111
`define OPC_LOAD    7'b0000011
`define OPC_STORE   7'b0100011
`define OPC_BRANCH  7'b1100011
`define OPC_JAL     7'b1101111
`define OPC_SYSTEM  7'b1110011

`endif
